//--- logic/imem_defs.svh
`ifndef IMEM_DEFS_SVH
`define IMEM_DEFS_SVH

// byte address seen by the core fetch port
`define IMEM_ADDR_W 14

// bit 13 selects the region
// clear means boot rom and set means loadable ram
`define IMEM_REGION_BIT 13

// region sizes in 32-bit words
`define IMEM_ROM_WORDS 64
`define IMEM_RAM_WORDS 2048

// loaded word count needs one bit more than the ram index
// so that a completely full ram (2048) can be represented
`define IMEM_CNT_W 12

`endif

//--- logic/imem_pkg.sv
`default_nettype none

package imem_pkg;

`include "imem_defs.svh"

   // one word of the boot image as it arrives from the flash reader side
   typedef struct packed {
      logic [31:0] data;        // instruction word
      logic        last;        // final word of the image
   } load_word_t;

   // fetch request from the core
   typedef struct packed {
      logic [`IMEM_ADDR_W-1:0] addr;   // byte address
   } fetch_req_t;

   // fetch response back to the core
   // data is forced to zero whenever err is set
   typedef struct packed {
      logic [31:0]             data;   // instruction
      logic                    err;    // misaligned or out of range
      logic [`IMEM_ADDR_W-1:0] addr;   // request address echoed for tracing
   } fetch_rsp_t;

endpackage

`default_nettype wire

//--- logic/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

// single entry register slice on a valid/ready stream
// full throughput since ready also looks at the downstream side
module pipe_stage #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  payload_t in_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output payload_t out_o,
   output logic     out_valid_o,
   input  logic     out_ready_i
);

   logic     run_q;    // low in reset and for one cycle after
   logic     full_q;   // entry holds an item
   payload_t data_q;   // stored payload, no reset needed

   // accept when empty or when the held item leaves this cycle
   assign in_ready_o = run_q & (~full_q | out_ready_i);

   assign out_o       = data_q;
   assign out_valid_o = full_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         run_q  <= 1'b0;
         full_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
         if (in_ready_o) begin
            full_q <= in_valid_i;   // refill or drain
         end
      end
   end

   // payload only moves on a real transfer
   always_ff @(posedge clk_i) begin
      if (in_valid_i && in_ready_o) begin
         data_q <= in_i;
      end
   end

endmodule

`default_nettype wire

//--- logic/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_defs.svh"

// fixed boot program
// clears a few registers, sets up the stack at the top of ram
// and jumps to the loaded image at byte address 0x2000
module boot_rom (
   input  logic [$clog2(`IMEM_ROM_WORDS)-1:0] word_i,
   output logic [31:0]                        data_o
);

   always_comb begin
      case (word_i)
         // register clear
         6'd0:    data_o = 32'h0000_0093;   // addi x1, x0, 0
         6'd1:    data_o = 32'h0000_0113;   // addi x2, x0, 0
         6'd2:    data_o = 32'h0000_0193;   // addi x3, x0, 0
         6'd3:    data_o = 32'h0000_0213;   // addi x4, x0, 0

         // x5 holds the ram base
         6'd4:    data_o = 32'h0000_22b7;   // lui  x5, 0x2

         // stack pointer just below the end of ram
         6'd5:    data_o = 32'h0000_4137;   // lui  x2, 0x4
         6'd6:    data_o = 32'hffc1_0113;   // addi x2, x2, -4

         // argument registers for the loaded program
         6'd7:    data_o = 32'h0000_0513;   // addi x10, x0, 0
         6'd8:    data_o = 32'h0000_0593;   // addi x11, x0, 0

         // a couple of nops to pad before the jump
         6'd9:    data_o = 32'h0000_0013;   // nop
         6'd10:   data_o = 32'h0000_0013;   // nop

         // hand over to ram
         6'd11:   data_o = 32'h0002_8067;   // jalr x0, 0(x5)

         // should never return here
         6'd12:   data_o = 32'h0000_006f;   // jal x0, 0 (spin)

         default: data_o = 32'h0000_0000;   // unused rom space reads zero
      endcase
   end

endmodule

`default_nettype wire

//--- logic/load_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_defs.svh"

// turns the incoming boot image into word writes from ram word 0 upward
// stops taking words after the last one or when ram is full
module load_sequencer (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  imem_pkg::load_word_t                word_i,
   input  logic                                word_valid_i,
   output logic                                word_ready_o,
   output logic                                wr_en_o,
   output logic [$clog2(`IMEM_RAM_WORDS)-1:0]  wr_word_o,
   output logic [31:0]                         wr_data_o,
   output logic [`IMEM_CNT_W-1:0]              fill_o,
   output logic                                done_o
);

   import imem_pkg::*;

   localparam int RAM_AW = $clog2(`IMEM_RAM_WORDS);
   localparam int CNT_W  = `IMEM_CNT_W;

   logic [CNT_W-1:0] fill_q;   // words written so far
   logic             done_q;   // image complete
   logic             accept;   // word taken this cycle
   logic             at_end;   // this word fills the last ram slot

   assign word_ready_o = ~done_q;                 // refuse everything once done
   assign accept       = word_valid_i & word_ready_o;
   assign at_end       = (fill_q == CNT_W'(`IMEM_RAM_WORDS - 1));

   // write goes out in the same cycle the word is accepted
   assign wr_en_o   = accept;
   assign wr_word_o = fill_q[RAM_AW-1:0];          // fill count doubles as write pointer
   assign wr_data_o = word_i.data;

   assign fill_o = fill_q;
   assign done_o = done_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fill_q <= '0;
         done_q <= 1'b0;
      end else if (accept) begin
         fill_q <= fill_q + 1'b1;                  // count rises with the write
         if (word_i.last || at_end) begin
            done_q <= 1'b1;                        // sticky until reset
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_defs.svh"

// fetch memory with boot rom and loadable ram regions
// one registered response that holds while the next stage stalls
module instr_mem (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  logic                                req_i,
   input  imem_pkg::fetch_req_t                addr_i,
   output logic                                gnt_o,
   input  logic                                wr_en_i,
   input  logic [$clog2(`IMEM_RAM_WORDS)-1:0]  wr_word_i,
   input  logic [31:0]                         wr_data_i,
   input  logic [`IMEM_CNT_W-1:0]              fill_i,
   output imem_pkg::fetch_rsp_t                rsp_o,
   output logic                                rsp_valid_o,
   input  logic                                rsp_ready_i
);

   import imem_pkg::*;

   localparam int ROM_AW = $clog2(`IMEM_ROM_WORDS);
   localparam int RAM_AW = $clog2(`IMEM_RAM_WORDS);
   localparam int IDX_W  = `IMEM_REGION_BIT - 2;   // word index below the region bit
   localparam int CNT_W  = `IMEM_CNT_W;

   logic [31:0]      ram [`IMEM_RAM_WORDS];   // loadable program memory
   logic [IDX_W-1:0] word_idx;
   logic             in_ram;
   logic             misaligned;
   logic             rom_oob;
   logic             ram_oob;
   logic             err;
   logic [31:0]      rom_data;
   logic [31:0]      rd_data;
   logic             run_q;
   logic             take;
   fetch_rsp_t       rsp_q;
   logic             rsp_valid_q;

   boot_rom i_boot_rom (
      .word_i (word_idx[ROM_AW-1:0]),
      .data_o (rom_data)
   );

   // write port from the sequencer
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         ram[wr_word_i] <= wr_data_i;
      end
   end

   // address decode
   assign in_ram     = addr_i.addr[`IMEM_REGION_BIT];
   assign word_idx   = addr_i.addr[`IMEM_REGION_BIT-1:2];
   assign misaligned = |addr_i.addr[1:0];
   assign rom_oob    = word_idx >= IDX_W'(`IMEM_ROM_WORDS);   // past the rom table
   assign ram_oob    = CNT_W'(word_idx) >= fill_i;            // not loaded yet

   assign err = misaligned | (in_ram ? ram_oob : rom_oob);

   // ram read is asynchronous and sees the array before this edge's write
   assign rd_data = err    ? 32'h0 :
                    in_ram ? ram[word_idx[RAM_AW-1:0]] : rom_data;

   // grant while the response slot is free or draining
   assign gnt_o = run_q & (~rsp_valid_q | rsp_ready_i);
   assign take  = req_i & gnt_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         run_q       <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         run_q <= 1'b1;              // grant opens the cycle after reset
         if (gnt_o) begin
            rsp_valid_q <= req_i;    // new response or slot empties
         end
      end
   end

   // response payload held while stalled
   always_ff @(posedge clk_i) begin
      if (take) begin
         rsp_q.data <= rd_data;
         rsp_q.err  <= err;
         rsp_q.addr <= addr_i.addr;
      end
   end

   assign rsp_o       = rsp_q;
   assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

//--- logic/imem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_defs.svh"

// instruction memory subsystem
// load stream -> register slice -> sequencer -> ram write port
// fetch port -> memory -> response register slice -> core
module imem_top (
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  imem_pkg::load_word_t load_i,
   input  logic                 load_valid_i,
   output logic                 load_ready_o,
   input  logic                 req_i,
   input  imem_pkg::fetch_req_t addr_i,
   output logic                 gnt_o,
   output imem_pkg::fetch_rsp_t rsp_o,
   output logic                 rsp_valid_o,
   input  logic                 rsp_ready_i,
   output logic                 boot_done_o
);

   import imem_pkg::*;

   localparam int RAM_AW = $clog2(`IMEM_RAM_WORDS);

   load_word_t            ld_word;        // slice output toward sequencer
   logic                  ld_valid;
   logic                  ld_ready;
   logic                  ld_in_valid;
   logic                  ld_in_ready;
   logic                  ld_stop;        // image complete or last word in flight
   logic                  wr_en;
   logic [RAM_AW-1:0]     wr_word;
   logic [31:0]           wr_data;
   logic [`IMEM_CNT_W-1:0] fill;
   fetch_rsp_t            mem_rsp;
   logic                  mem_rsp_valid;
   logic                  mem_rsp_ready;

   // close the load port once the last word has been seen
   assign ld_stop      = boot_done_o | (ld_valid & ld_word.last);
   assign ld_in_valid  = load_valid_i & ~ld_stop;
   assign load_ready_o = ld_in_ready & ~ld_stop;

   pipe_stage #(.payload_t(load_word_t)) i_load_stage (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_i        (load_i),
      .in_valid_i  (ld_in_valid),
      .in_ready_o  (ld_in_ready),
      .out_o       (ld_word),
      .out_valid_o (ld_valid),
      .out_ready_i (ld_ready)
   );

   load_sequencer i_load_sequencer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .word_i       (ld_word),
      .word_valid_i (ld_valid),
      .word_ready_o (ld_ready),
      .wr_en_o      (wr_en),
      .wr_word_o    (wr_word),
      .wr_data_o    (wr_data),
      .fill_o       (fill),
      .done_o       (boot_done_o)
   );

   instr_mem i_instr_mem (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (req_i),
      .addr_i      (addr_i),
      .gnt_o       (gnt_o),
      .wr_en_i     (wr_en),
      .wr_word_i   (wr_word),
      .wr_data_i   (wr_data),
      .fill_i      (fill),
      .rsp_o       (mem_rsp),
      .rsp_valid_o (mem_rsp_valid),
      .rsp_ready_i (mem_rsp_ready)
   );

   // second response slot so the memory can grant back to back
   pipe_stage #(.payload_t(fetch_rsp_t)) i_rsp_stage (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_i        (mem_rsp),
      .in_valid_i  (mem_rsp_valid),
      .in_ready_o  (mem_rsp_ready),
      .out_o       (rsp_o),
      .out_valid_o (rsp_valid_o),
      .out_ready_i (rsp_ready_i)
   );

endmodule

`default_nettype wire

//--- test/imem_sva.sv
`timescale 1ns/1ps
`default_nettype none

// port level protocol properties, bound into imem_top
module imem_sva (
   input logic                 clk_i,
   input logic                 rst_i,
   input logic                 load_ready_o,
   input logic                 gnt_o,
   input imem_pkg::fetch_rsp_t rsp_o,
   input logic                 rsp_valid_o,
   input logic                 rsp_ready_i,
   input logic                 boot_done_o,
   input logic                 mem_rsp_valid   // memory response slot occupied
);

   // a stalled response must not change under the core
   rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o))
      else $error("rsp_o changed while stalled");

   // second reset cycle onward, all handshake outputs quiet
   reset_quiet: assert property (@(posedge clk_i)
      rst_i && $past(rst_i) |-> !load_ready_o && !gnt_o && !rsp_valid_o)
      else $error("handshake output high during reset");

   // both response slots full and core stalling, so no new grant
   gnt_backoff: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_o && !rsp_ready_i && mem_rsp_valid |-> !gnt_o)
      else $error("grant given with no response slot free");

   load_closed: assert property (@(posedge clk_i) disable iff (rst_i)
      boot_done_o |-> !load_ready_o)   // image complete, port stays shut
      else $error("load_ready_o high after boot done");

endmodule

bind imem_top imem_sva i_imem_sva (
   .clk_i         (clk_i),
   .rst_i         (rst_i),
   .load_ready_o  (load_ready_o),
   .gnt_o         (gnt_o),
   .rsp_o         (rsp_o),
   .rsp_valid_o   (rsp_valid_o),
   .rsp_ready_i   (rsp_ready_i),
   .boot_done_o   (boot_done_o),
   .mem_rsp_valid (mem_rsp_valid)
);

`default_nettype wire

//--- test/imem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "imem_defs.svh"

module imem_tb;

   import imem_pkg::*;

   localparam int LOAD_TO = 50;   // cycles a load word may wait
   localparam int GNT_TO  = 50;
   localparam int RSP_TO  = 50;   // idle cycles before a response counts as lost

   logic        clk_i = 1'b0;
   logic        rst_i;
   load_word_t  load_i;
   logic        load_valid_i;
   logic        load_ready_o;
   logic        req_i;
   fetch_req_t  addr_i;
   logic        gnt_o;
   fetch_rsp_t  rsp_o;
   logic        rsp_valid_o;
   logic        rsp_ready_i;
   logic        boot_done_o;

   logic [31:0] rnd_state = 32'hf235_c16b;
   int          cyc = 0;          // rising edges so far, read at the falling edge
   logic        stall_on = 1'b0;
   fetch_rsp_t  batch_q[$];       // fetches collected for the next burst
   fetch_rsp_t  exp_q[$];         // granted and still waiting for a response
   int          gnt_cyc_q[$];     // cycle of each grant, same order

   imem_top i_imem_top (.*);

   always #10 clk_i = ~clk_i;
   always @(posedge clk_i) cyc <= cyc + 1;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[ERROR] %0t: fetch %h gave data %h err %b addr %h, want %h err %b",
            $time, exp.addr, got.data, got.err, got.addr, exp.data, exp.err));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_run($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // tasks start and end at a falling edge, inputs change 2 ns after a rising edge
   task automatic offer_load(input load_word_t w);
      int waited;
      rnd_state = xorshift32(rnd_state);
      repeat (rnd_state[1:0]) @(posedge clk_i);   // random idle gap
      @(posedge clk_i);
      #2;
      load_i       = w;
      load_valid_i = 1'b1;
      waited       = 0;
      @(negedge clk_i);
      while (!load_ready_o) begin
         waited++;
         if (waited > LOAD_TO) stop_run("timeout: load word never accepted");
         @(negedge clk_i);
      end
      @(posedge clk_i);   // word transfers on this edge
      #2;
      load_valid_i = 1'b0;
      @(negedge clk_i);
   endtask

   // word held on the port after boot, must never be taken
   task automatic offer_extra(input logic [31:0] d);
      @(posedge clk_i);
      #2;
      load_i       = load_word_t'({d, 1'b0});
      load_valid_i = 1'b1;
      repeat (20) begin
         @(negedge clk_i);
         check_flag(load_ready_o, 1'b0, "load_ready_o after boot");
      end
      @(posedge clk_i);
      #2;
      load_valid_i = 1'b0;
      @(negedge clk_i);
   endtask

   // stage plus sequencer write, then fill and boot_done are current
   task automatic let_load_land();
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
   endtask

   task automatic issue_fetches();
      fetch_rsp_t e;
      int         waited;
      while (batch_q.size() > 0) begin
         e = batch_q.pop_front();
         @(posedge clk_i);
         #2;
         req_i       = 1'b1;
         addr_i.addr = e.addr;
         waited      = 0;
         @(negedge clk_i);
         while (!gnt_o) begin
            waited++;
            if (waited > GNT_TO) stop_run("timeout: fetch request never granted");
            @(negedge clk_i);
         end
         exp_q.push_back(e);   // taken on the coming edge
         gnt_cyc_q.push_back(cyc);
      end
      @(posedge clk_i);
      #2;
      req_i = 1'b0;
   endtask

   task automatic collect_rsps(input int n);
      int got;
      int idle;
      int lat;
      got  = 0;
      idle = 0;
      while (got < n) begin
         @(posedge clk_i);
         #2;
         rnd_state   = xorshift32(rnd_state);
         rsp_ready_i = ~stall_on | rnd_state[0];   // half the cycles stall
         @(negedge clk_i);
         if (rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) stop_run("response arrived with no fetch outstanding");
            check_rsp(rsp_o, exp_q.pop_front());
            lat = cyc - gnt_cyc_q.pop_front();
            if (!stall_on && lat != 2) begin
               stop_run($sformatf("[ERROR] %0t: response latency %0d, expected 2", $time, lat));
            end
            got++;
            idle = 0;
         end else begin
            idle++;
            if (idle > RSP_TO) stop_run("timeout: fetch response missing");
         end
      end
   endtask

   task automatic run_burst();
      int n;
      n = batch_q.size();
      if (n > 0) begin
         let_load_land();
         fork
            issue_fetches();
            collect_rsps(n);
         join
         @(posedge clk_i);
         @(negedge clk_i);
         check_flag(rsp_valid_o, 1'b0, "rsp_valid_o after burst");   // nothing extra
      end
   endtask

   initial begin
      int            fd;
      int            code;
      logic [7:0]    kind;
      logic [31:0]   a;
      logic [31:0]   d;
      logic [31:0]   f;
      logic [1023:0] skip;
      fetch_rsp_t    e;
      rst_i        = 1'b1;
      load_i       = '0;
      load_valid_i = 1'b0;
      req_i        = 1'b0;
      addr_i       = '0;
      rsp_ready_i  = 1'b1;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      check_flag(load_ready_o, 1'b0, "load_ready_o in reset");
      check_flag(gnt_o, 1'b0, "gnt_o in reset");
      check_flag(rsp_valid_o, 1'b0, "rsp_valid_o in reset");
      check_flag(boot_done_o, 1'b0, "boot_done_o in reset");
      repeat (14) @(posedge clk_i);   // 16 edges with reset high
      #2;
      rst_i = 1'b0;
      @(negedge clk_i);
      @(negedge clk_i);   // first cycle out of reset
      check_flag(load_ready_o, 1'b1, "load_ready_o after reset");
      check_flag(gnt_o, 1'b1, "gnt_o after reset");
      fd = $fopen("test/imem_patterns.txt", "r");
      if (fd == 0) stop_run("cannot open test/imem_patterns.txt");
      code = $fscanf(fd, " %c", kind);
      while (code == 1) begin
         if (kind != "F" && kind != "#") run_burst();   // any other line ends a burst
         case (kind)
            "#": code = $fgets(skip, fd);
            "F": begin
               code   = $fscanf(fd, "%h %h %h", a, d, f);
               e.addr = a[`IMEM_ADDR_W-1:0];
               e.data = d;
               e.err  = f[0];
               batch_q.push_back(e);
            end
            "L": begin
               code = $fscanf(fd, "%h %h", d, f);
               offer_load(load_word_t'({d, f[0]}));
            end
            "X": begin
               code = $fscanf(fd, "%h", d);
               offer_extra(d);
            end
            "D": begin
               code = $fscanf(fd, "%h", f);
               let_load_land();
               check_flag(boot_done_o, f[0], "boot_done_o");
            end
            "S": begin
               code     = $fscanf(fd, "%h", f);
               stall_on = f[0];
            end
            default: stop_run("unknown line kind in test/imem_patterns.txt");
         endcase
         if (code < 1) stop_run("malformed line in test/imem_patterns.txt");
         code = $fscanf(fd, " %c", kind);
      end
      run_burst();
      $fclose(fd);
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/imem_pkg.sv
logic/pipe_stage.sv
logic/boot_rom.sv
logic/load_sequencer.sv
logic/instr_mem.sv
logic/imem_top.sv
test/imem_sva.sv
test/imem_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module imem_tb -Mdir obj_dir -f all.f
	obj_dir/Vimem_tb

clean:
	rm -rf obj_dir

//--- test/imem_patterns.txt
# L data last | F byte_addr expected_data expected_err | X extra_load_data
# D expected_boot_done | S response_stalls (0 ready held high, 1 random)
S 0
F 0000 00000093 0
F 0018 ffc10113 0
F 002c 00028067 0
F 0030 0000006f 0
F 0034 00000000 0
F 2000 00000000 1
D 0
L 11110001 0
L 22220002 0
L 33330003 0
D 0
F 2008 33330003 0
F 200c 00000000 1
S 1
L 44440004 0
L 55550005 0
L 66660006 0
L 77770007 1
D 1
X deadbeef
F 2000 11110001 0
F 2004 22220002 0
F 200c 44440004 0
F 2014 66660006 0
F 2018 77770007 0
F 201c 00000000 1
F 0002 00000000 1
F 2001 00000000 1
F 0100 00000000 1
F 1ffc 00000000 1
F 3ffc 00000000 1
S 0
F 2010 55550005 0
F 0000 00000093 0
